/* ftdi_pkg.sv */
/*
 * shared widths, localparams and types for the host command link
 * byte and address types, command struct, FSM state enums
 */

package ftdi_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int NUM_REGS   = 16;
    localparam int REG_AW     = $clog2(NUM_REGS);
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    // ----------------------------------------
    // basic vectors
    // ----------------------------------------
    typedef logic [7:0]         byte_t;
    typedef logic [7:0]         addr_t;
    typedef logic [15:0]        len_t;
    // one extra bit so a full credit count of FIFO_DEPTH fits
    typedef logic [FIFO_AW:0]   credit_t;

    // command header bytes
    localparam byte_t CMD_WRITE = 8'h01;
    localparam byte_t CMD_READ  = 8'h02;

    // bus FSM prefers host-to-board reads when both sides are ready
    localparam bit READ_PRIORITY = 1'b1;

    // configuration bank as seen from outside
    typedef byte_t [NUM_REGS-1:0] reg_bank_t;

    // one register access per cycle
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        byte_t wdata;
    } reg_req_t;

    typedef enum logic [2:0] {
        S_HEADER,
        S_ADDR,
        S_LEN_HI,
        S_LEN_LO,
        S_WRITE,
        S_READ
    } sorter_state_t;

    typedef enum logic [1:0] {
        B_IDLE,
        B_OE,
        B_READ,
        B_WRITE
    } bus_state_t;

endpackage

/* byte_fifo.sv */
/*
 * synchronous first-word-fall-through byte FIFO
 * used for both the receive and the transmit direction
 */
`timescale 1ns/10ps

module byte_fifo import ftdi_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  byte_t din,
    input  logic  pop,
    output byte_t dout,
    output logic  empty,
    output logic  almost_full
);

    byte_t                mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0]   wr_ptr;
    logic [FIFO_AW-1:0]   rd_ptr;
    logic [FIFO_AW:0]     count;
    logic                 full;
    logic                 do_push;
    logic                 do_pop;

    assign full        = count == (FIFO_AW+1)'(FIFO_DEPTH);
    assign empty       = count == '0;
    // at most one free slot left
    assign almost_full = count >= (FIFO_AW+1)'(FIFO_DEPTH - 1);

    // illegal push or pop is dropped here
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head byte is visible as soon as it is stored
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (FIFO_AW+1)'(do_push) - (FIFO_AW+1)'(do_pop);
        end
    end

endmodule

/* ftdi_bus_fsm.sv */
/*
 * FT245-style chip side state machine
 * read and write strobes, FIFO push/pop, transmit credit return
 */
`timescale 1ns/10ps

module ftdi_bus_fsm import ftdi_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic rxf_n,
    input  logic txe_n,
    input  logic rx_almost_full,
    input  logic tx_empty,
    output logic rd_n,
    output logic wr_n,
    output logic oe_n,
    output logic rx_push,
    output logic tx_pop,
    output logic tx_credit
);

    bus_state_t state;
    logic       rd_ready;
    logic       wr_ready;

    // read needs host data and two free receive slots
    assign rd_ready = !rxf_n && !rx_almost_full;
    assign wr_ready = !txe_n && !tx_empty;

    // bytes actually taken on this edge
    assign rx_push   = !rxf_n && !rd_n;
    assign tx_pop    = !txe_n && !wr_n;
    // every byte handed to the host frees one transmit slot
    assign tx_credit = tx_pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= B_IDLE;
            rd_n  <= 1'b1;
            wr_n  <= 1'b1;
            oe_n  <= 1'b1;
        end else begin
            case (state)
                B_IDLE: begin
                    if (rd_ready && (READ_PRIORITY || !wr_ready)) begin
                        state <= B_OE;
                        oe_n  <= 1'b0;
                    end else if (wr_ready) begin
                        state <= B_WRITE;
                        wr_n  <= 1'b0;
                    end
                end
                // output enable one cycle ahead of the first rd_n
                B_OE: begin
                    if (rd_ready) begin
                        state <= B_READ;
                        rd_n  <= 1'b0;
                    end else begin
                        state <= B_IDLE;
                        oe_n  <= 1'b1;
                    end
                end
                B_READ: begin
                    if (!rd_ready) begin
                        state <= B_IDLE;
                        rd_n  <= 1'b1;
                        oe_n  <= 1'b1;
                    end
                end
                // one byte per write phase as only empty is known
                B_WRITE: begin
                    state <= B_IDLE;
                    wr_n  <= 1'b1;
                end
                default: state <= B_IDLE;
            endcase
        end
    end

endmodule

/* burst_counter.sv */
/*
 * remaining length and current address of one command burst
 */
`timescale 1ns/10ps

module burst_counter import ftdi_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  load,
    input  addr_t start_addr,
    input  len_t  length,
    input  logic  step,
    output addr_t addr,
    output logic  last
);

    len_t remaining;

    // one access left in this burst
    assign last = remaining == len_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
            addr      <= '0;
        end else if (load) begin
            remaining <= length;
            addr      <= start_addr;
        end else if (step) begin
            remaining <= remaining - 1'b1;
            // wraps at 8 bits
            addr      <= addr + 1'b1;
        end
    end

endmodule

/* order_sorter.sv */
/*
 * command parser: header, address, 16-bit length, data phase
 * keeps transmit credits and issues register requests
 */
`timescale 1ns/10ps

module order_sorter import ftdi_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  byte_t    rx_data,
    input  logic     rx_empty,
    output logic     rx_pop,
    input  logic     tx_credit,
    output reg_req_t req
);

    sorter_state_t state;
    logic          is_read;
    addr_t         start_addr;
    byte_t         len_hi;
    credit_t       credits;
    logic          rx_take;
    logic          rd_issue;
    logic          wr_issue;
    logic          load;
    logic          step;
    logic          last;
    addr_t         addr;
    len_t          length;

    // ----------------------------------------
    // handshakes
    // ----------------------------------------
    assign length   = {len_hi, rx_data};
    // reads consume no host bytes
    assign rx_take  = !rx_empty && (state != S_READ);
    assign rx_pop   = rx_take;
    assign wr_issue = (state == S_WRITE) && rx_take;
    assign rd_issue = (state == S_READ) && (credits != '0);
    assign load     = (state == S_LEN_LO) && rx_take;
    assign step     = wr_issue || rd_issue;

    always_comb begin
        req.read  = rd_issue;
        req.write = wr_issue;
        req.addr  = addr;
        req.wdata = rx_data;
    end

    burst_counter i_burst_counter (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .start_addr (start_addr),
        .length     (length),
        .step       (step),
        .addr       (addr),
        .last       (last)
    );

    // ----------------------------------------
    // parser FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_HEADER;
            is_read <= 1'b0;
        end else begin
            case (state)
                S_HEADER: begin
                    // unknown headers are dropped alone
                    if (rx_take && (rx_data == CMD_WRITE || rx_data == CMD_READ)) begin
                        is_read <= rx_data == CMD_READ;
                        state   <= S_ADDR;
                    end
                end
                S_ADDR:   if (rx_take) state <= S_LEN_HI;
                S_LEN_HI: if (rx_take) state <= S_LEN_LO;
                S_LEN_LO: begin
                    if (rx_take) begin
                        if (length == '0) begin
                            state <= S_HEADER;
                        end else begin
                            state <= is_read ? S_READ : S_WRITE;
                        end
                    end
                end
                S_WRITE, S_READ: if (step && last) state <= S_HEADER;
                default: state <= S_HEADER;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_take && state == S_ADDR) begin
            start_addr <= rx_data;
        end
        if (rx_take && state == S_LEN_HI) begin
            len_hi <= rx_data;
        end
    end

    // free transmit slots not yet claimed by a read
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_t'(FIFO_DEPTH);
        end else begin
            credits <= credits + credit_t'(tx_credit) - credit_t'(rd_issue);
        end
    end

endmodule

/* register_file.sv */
/*
 * configuration register bank
 * writes at end of request cycle, read data one cycle later
 */
`timescale 1ns/10ps

module register_file import ftdi_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_req_t  req,
    output byte_t     rd_data,
    output logic      rd_valid,
    output reg_bank_t config_regs
);

    reg_bank_t         regs;
    logic              in_bank;
    logic [REG_AW-1:0] idx;

    // addresses above the bank ignore writes and read as zero
    assign in_bank     = req.addr < addr_t'(NUM_REGS);
    assign idx         = req.addr[REG_AW-1:0];
    assign config_regs = regs;

    // ----------------------------------------
    // bank and read strobe
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            regs     <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req.read;
            if (req.write && in_bank) begin
                regs[idx] <= req.wdata;
            end
        end
    end

    // read data goes straight to the transmit FIFO
    always_ff @(posedge clk) begin
        if (req.read) begin
            rd_data <= in_bank ? regs[idx] : '0;
        end
    end

endmodule

/* ftdi_top.sv */
/*
 * host command link top level
 * bus FSM, receive and transmit FIFOs, parser, register bank
 */
`timescale 1ns/10ps

module ftdi_top import ftdi_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rxf_n,
    input  logic      txe_n,
    input  byte_t     ftdi_din,
    output logic      rd_n,
    output logic      wr_n,
    output logic      oe_n,
    output byte_t     ftdi_dout,
    output reg_bank_t config_regs
);

    logic     rx_push;
    logic     rx_pop;
    logic     rx_empty;
    logic     rx_almost_full;
    byte_t    rx_data;
    logic     tx_pop;
    logic     tx_empty;
    logic     tx_credit;
    reg_req_t req;
    byte_t    rd_data;
    logic     rd_valid;

    ftdi_bus_fsm i_bus_fsm (
        .clk            (clk),
        .rst            (rst),
        .rxf_n          (rxf_n),
        .txe_n          (txe_n),
        .rx_almost_full (rx_almost_full),
        .tx_empty       (tx_empty),
        .rd_n           (rd_n),
        .wr_n           (wr_n),
        .oe_n           (oe_n),
        .rx_push        (rx_push),
        .tx_pop         (tx_pop),
        .tx_credit      (tx_credit)
    );

    // host to board
    byte_fifo i_rx_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (rx_push),
        .din         (ftdi_din),
        .pop         (rx_pop),
        .dout        (rx_data),
        .empty       (rx_empty),
        .almost_full (rx_almost_full)
    );

    // board to host with its level tracked by credits
    byte_fifo i_tx_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (rd_valid),
        .din         (rd_data),
        .pop         (tx_pop),
        .dout        (ftdi_dout),
        .empty       (tx_empty),
        .almost_full ()
    );

    order_sorter i_order_sorter (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_empty  (rx_empty),
        .rx_pop    (rx_pop),
        .tx_credit (tx_credit),
        .req       (req)
    );

    register_file i_register_file (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .config_regs (config_regs)
    );

endmodule

/* ftdi_asserts.sv */
/*
 * chip strobe and FIFO overflow assertions, bound into the RTL
 */
`timescale 1ns/10ps

module ftdi_asserts (
    input logic clk,
    input logic rst,
    input logic rd_n,
    input logic wr_n,
    input logic oe_n,
    input logic push,
    input logic full
);

    // read and write phases never overlap on the chip bus
    a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (rst) !(!rd_n && !wr_n))
        else $error("rd_n and wr_n are low together");

    a_oe_with_rd: assert property (@(posedge clk) disable iff (rst) !rd_n |-> !oe_n)
        else $error("rd_n is low while oe_n is high");

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("push into a full FIFO");

endmodule

// strobe checks only
bind ftdi_bus_fsm ftdi_asserts i_bus_asserts (
    .clk  (clk),
    .rst  (rst),
    .rd_n (rd_n),
    .wr_n (wr_n),
    .oe_n (oe_n),
    .push (1'b0),
    .full (1'b0)
);

// overflow check only
bind byte_fifo ftdi_asserts i_fifo_asserts (
    .clk  (clk),
    .rst  (rst),
    .rd_n (1'b1),
    .wr_n (1'b1),
    .oe_n (1'b1),
    .push (push),
    .full (full)
);

/* ftdi_checker.sv */
/*
 * reply byte and register bank checker
 * one result line per test, error and test counts
 */
`timescale 1ns/10ps

module ftdi_checker import ftdi_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      txe_n,
    input logic      wr_n,
    input logic      rd_n,
    input logic      oe_n,
    input byte_t     ftdi_dout,
    input reg_bank_t config_regs
);

    byte_t expected[$];
    byte_t exp_byte;
    int    error_count = 0;
    int    errors_before = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    function automatic void add_expected(input byte_t b);
        expected.push_back(b);
    endfunction

    function automatic int outstanding();
        return expected.size();
    endfunction

    function automatic int total_errors();
        return error_count;
    endfunction

    function automatic void check_high(input string name, input logic value);
        if (value !== 1'b1) begin
            $display("Fail %s: expected 0x1, got 0x%0h", name, value);
            error_count++;
        end
    endfunction

    // ----------------------------------------
    // reply bytes taken by the host
    // ----------------------------------------
    always @(posedge clk) begin
        if (!rst && !txe_n && !wr_n) begin
            if (expected.size() == 0) begin
                $display("unexpected reply byte 0x%02h arrived when no reply was due",
                         ftdi_dout);
                error_count++;
            end else begin
                exp_byte = expected.pop_front();
                if (ftdi_dout !== exp_byte) begin
                    $display("Fail ftdi_dout: expected 0x%02h, got 0x%02h",
                             exp_byte, ftdi_dout);
                    error_count++;
                end
            end
        end
    end

    task automatic check_reset_outputs();
        check_high("rd_n", rd_n);
        check_high("wr_n", wr_n);
        check_high("oe_n", oe_n);
    endtask

    // leftover replies, then the whole bank against the model
    task automatic end_test(input string name, input reg_bank_t model_regs);
        if (expected.size() > 0) begin
            $display("%0d expected reply bytes never arrived", expected.size());
            error_count += expected.size();
            expected.delete();
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            if (config_regs[REG_AW'(i)] !== model_regs[REG_AW'(i)]) begin
                $display("Fail config_regs[%0d]: expected 0x%02h, got 0x%02h",
                         i, model_regs[REG_AW'(i)], config_regs[REG_AW'(i)]);
                error_count++;
            end
        end
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    task automatic print_counts();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    endtask

endmodule

/* tb_ftdi_top.sv */
/*
 * testbench for the host command link
 * clock, reset, chip emulation, reference model, tests, watchdog
 */
`timescale 1ns/10ps

module tb_ftdi_top import ftdi_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        rxf_n;
    logic        txe_n;
    byte_t       ftdi_din;
    logic        rd_n;
    logic        wr_n;
    logic        oe_n;
    byte_t       ftdi_dout;
    reg_bank_t   config_regs;

    byte_t       host_q[$];
    byte_t       reply_q[$];
    byte_t       wr_data[$];
    reg_bank_t   shadow;
    logic [31:0] rng;
    int          stall_mode;
    int          total_bytes = 0;
    int          watch_cycles;
    logic        took;

    ftdi_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .rxf_n       (rxf_n),
        .txe_n       (txe_n),
        .ftdi_din    (ftdi_din),
        .rd_n        (rd_n),
        .wr_n        (wr_n),
        .oe_n        (oe_n),
        .ftdi_dout   (ftdi_dout),
        .config_regs (config_regs)
    );

    ftdi_checker i_checker (
        .clk         (clk),
        .rst         (rst),
        .txe_n       (txe_n),
        .wr_n        (wr_n),
        .rd_n        (rd_n),
        .oe_n        (oe_n),
        .ftdi_dout   (ftdi_dout),
        .config_regs (config_regs)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ----------------------------------------
    // chip emulation
    // ----------------------------------------
    always @(posedge clk) begin
        took = !rxf_n && !rd_n;
        #1;
        if (took && host_q.size() > 0) begin
            void'(host_q.pop_front());
        end
        rxf_n    = host_q.size() == 0;
        ftdi_din = host_q.size() > 0 ? host_q[0] : 8'h00;
        case (stall_mode)
            0: txe_n = 1'b0;
            1: txe_n = 1'b1;
            default: begin
                rng   = xorshift(rng);
                txe_n = rng[1:0] == 2'b00;
            end
        endcase
    end

    // shadow bank update and expected replies for one command
    function automatic void ref_access(input byte_t hdr, input addr_t addr, input len_t len,
                                       input byte_t wdata[$]);
        addr_t a;
        reply_q.delete();
        if (hdr == CMD_WRITE || hdr == CMD_READ) begin
            for (int i = 0; i < int'(len); i++) begin
                a = addr + addr_t'(i);
                if (hdr == CMD_WRITE && a < addr_t'(NUM_REGS)) begin
                    shadow[a[REG_AW-1:0]] = wdata[i];
                end else if (hdr == CMD_READ) begin
                    reply_q.push_back(a < addr_t'(NUM_REGS) ? shadow[a[REG_AW-1:0]] : 8'h00);
                end
            end
        end
    endfunction

    task automatic put_byte(input byte_t b);
        host_q.push_back(b);
        total_bytes++;
    endtask

    task automatic send_cmd(input byte_t hdr, input addr_t addr, input len_t len,
                            input byte_t wdata[$]);
        put_byte(hdr);
        put_byte(addr);
        put_byte(len[15:8]);
        put_byte(len[7:0]);
        if (hdr == CMD_WRITE) begin
            foreach (wdata[i]) begin
                put_byte(wdata[i]);
            end
        end
        ref_access(hdr, addr, len, wdata);
        foreach (reply_q[i]) begin
            i_checker.add_expected(reply_q[i]);
        end
    endtask

    // wait for host bytes and replies to drain, then let the bank settle
    task automatic finish_test(input string name);
        int waited;
        int limit;
        waited = 0;
        limit  = (host_q.size() + i_checker.outstanding()) * 40 + 400;
        while ((host_q.size() > 0 || i_checker.outstanding() > 0) && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        repeat (20) @(posedge clk);
        i_checker.end_test(name, shadow);
    endtask

    initial begin : main
        byte_t hdr;
        addr_t addr;
        len_t  len;
        clk        = 1'b0;
        rst        = 1'b1;
        rxf_n      = 1'b1;
        txe_n      = 1'b1;
        ftdi_din   = 8'h00;
        stall_mode = 0;
        rng        = 32'd27;
        shadow     = '0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        i_checker.check_reset_outputs();
        finish_test("reset");

        wr_data.delete();
        for (int i = 0; i < 7; i++) begin
            wr_data.push_back(8'hA0 + byte_t'(i));
        end
        send_cmd(CMD_WRITE, 8'd3, 16'd7, wr_data);
        finish_test("write burst");

        // second read wraps from 0xff to 0x00
        wr_data.delete();
        send_cmd(CMD_READ, 8'd0, 16'd20, wr_data);
        send_cmd(CMD_READ, 8'hFE, 16'd6, wr_data);
        finish_test("read burst");

        stall_mode = 1;
        send_cmd(CMD_READ, 8'd0, 16'd40, wr_data);
        for (int i = 0; i < 12; i++) begin
            wr_data.push_back(8'h30 + byte_t'(i * 3));
        end
        send_cmd(CMD_WRITE, 8'd2, 16'd12, wr_data);
        wr_data.delete();
        send_cmd(CMD_READ, 8'd0, 16'd6, wr_data);
        repeat (200) @(posedge clk);
        stall_mode = 0;
        finish_test("back-pressure");

        put_byte(8'h00);
        put_byte(8'h7F);
        put_byte(8'hFF);
        send_cmd(CMD_WRITE, 8'd5, 16'd0, wr_data);
        send_cmd(CMD_READ, 8'd5, 16'd0, wr_data);
        put_byte(8'h03);
        wr_data = '{8'h5A, 8'hC3};
        send_cmd(CMD_WRITE, 8'd0, 16'd2, wr_data);
        wr_data.delete();
        send_cmd(CMD_READ, 8'd0, 16'd3, wr_data);
        finish_test("ignored input");

        stall_mode = 2;
        for (int n = 0; n < 30; n++) begin
            rng  = xorshift(rng);
            hdr  = rng[0] ? CMD_WRITE : CMD_READ;
            addr = rng[15:13] == 3'b000 ? 8'hFA : {3'b000, rng[12:8]};
            len  = len_t'(rng[19:16]);
            wr_data.delete();
            if (hdr == CMD_WRITE) begin
                for (int j = 0; j < int'(len); j++) begin
                    rng = xorshift(rng);
                    wr_data.push_back(rng[7:0]);
                end
            end
            send_cmd(hdr, addr, len, wr_data);
        end
        finish_test("random traffic");

        i_checker.print_counts();
        if (i_checker.total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // limit grows with every queued host byte
    initial begin : watchdog
        watch_cycles = 0;
        while (watch_cycles <= total_bytes * 40 + 2000) begin
            @(posedge clk);
            watch_cycles++;
        end
        $display("watchdog expired after %0d cycles with %0d reply bytes still missing",
                 watch_cycles, i_checker.outstanding());
        $display("Test failed");
        $finish;
    end

endmodule

/* all.f */
ftdi_pkg.sv
byte_fifo.sv
ftdi_bus_fsm.sv
burst_counter.sv
order_sorter.sv
register_file.sv
ftdi_top.sv
ftdi_asserts.sv
ftdi_checker.sv
tb_ftdi_top.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_ftdi_top -f all.f -o sim_tb || exit 1
out="$(./obj_dir/sim_tb 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Test completed successfully" && exit 0 || exit 1
